// ==== ooo.f ====
src/ooo_pkg.sv
src/rename_map.sv
src/prf.sv
src/rs.sv
src/alu_cdb.sv
src/rob.sv
src/ooo.sv
test/ooo_properties.sv
test/ooo_tb.sv

// ==== Bender.yml ====
package:
  name: ooo

sources:
  - files:
      - src/ooo_pkg.sv
      - src/rename_map.sv
      - src/prf.sv
      - src/rs.sv
      - src/alu_cdb.sv
      - src/rob.sv
      - src/ooo.sv
  - target: test
    files:
      - test/ooo_properties.sv
      - test/ooo_tb.sv

// ==== test/ooo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_tb;

    localparam int n_instr     = 400;
    localparam int ready_limit = 10;
    localparam int run_limit   = 20 * n_instr;
    localparam int idle_limit  = 64;

    typedef struct {
        ooo_pkg::alu_op_t op;
        ooo_pkg::arn_t    dest;
        ooo_pkg::arn_t    src1;
        ooo_pkg::arn_t    src2;
        ooo_pkg::word_t   imm;
    } instr_t;

    logic             clock = 1'b0;
    logic             reset;
    logic             dispatch_valid;
    ooo_pkg::alu_op_t dispatch_op;
    ooo_pkg::arn_t    dispatch_dest;
    ooo_pkg::arn_t    dispatch_src1;
    ooo_pkg::arn_t    dispatch_src2;
    ooo_pkg::word_t   dispatch_imm;
    logic             dispatch_ready;
    logic             commit_valid;
    ooo_pkg::arn_t    commit_dest;
    ooo_pkg::word_t   commit_value;

    integer         seed;
    ooo_pkg::word_t arch_regs [ooo_pkg::arch_regs];
    instr_t         in_flight [$];
    instr_t         cur;
    logic           holding;
    ooo_pkg::arn_t  last_dest;
    int             burst_left;
    int             sent;
    int             committed;
    int             idle_cycles;
    int             ready_low_cycles;

    ooo ooo_i (
        .clock(clock),
        .reset(reset),
        .dispatch_valid(dispatch_valid),
        .dispatch_op(dispatch_op),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .dispatch_imm(dispatch_imm),
        .dispatch_ready(dispatch_ready),
        .commit_valid(commit_valid),
        .commit_dest(commit_dest),
        .commit_value(commit_value)
    );

    always #50 clock = ~clock;

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_dest(input ooo_pkg::arn_t actual, input ooo_pkg::arn_t expected);
        if (actual !== expected) begin
            $display("FAILED commit_dest: got 0x%0h, expected 0x%0h", actual, expected);
            abort_run();
        end
    endtask

    task automatic check_value(input ooo_pkg::word_t actual, input ooo_pkg::word_t expected);
        if (actual !== expected) begin
            $display("FAILED commit_value: got 0x%08h, expected 0x%08h", actual, expected);
            abort_run();
        end
    endtask

    // architectural result of one instruction
    function automatic ooo_pkg::word_t model_result(input instr_t ins);
        ooo_pkg::word_t a;
        ooo_pkg::word_t b;
        a = arch_regs[ins.src1];
        b = arch_regs[ins.src2];
        case (ins.op)
            ooo_pkg::alu_add: return a + b;
            ooo_pkg::alu_sub: return a - b;
            ooo_pkg::alu_and: return a & b;
            ooo_pkg::alu_xor: return a ^ b;
            default:          return ins.imm;
        endcase
    endfunction

    task automatic make_instr();
        int unsigned r;
        r = $unsigned($random(seed));
        cur.op   = ooo_pkg::alu_op_t'(r % 5);
        cur.dest = ooo_pkg::arn_t'($random(seed));
        if (burst_left > 0) begin
            // dependent chain on the register just written
            cur.src1 = last_dest;
            cur.src2 = ($random(seed) & 1) ? last_dest : ooo_pkg::arn_t'($random(seed));
            burst_left--;
        end else begin
            cur.src1 = ooo_pkg::arn_t'($random(seed));
            cur.src2 = ooo_pkg::arn_t'($random(seed));
            if (((r >> 8) % 6) == 0) begin
                burst_left = 3 + ((r >> 12) % 5);
            end
        end
        if ((r >> 16) & 1) begin
            cur.imm = $random(seed);
        end else begin
            cur.imm = ooo_pkg::word_t'((r >> 20) & 32'hff);
        end
        last_dest = cur.dest;
    endtask

    function automatic logic want_dispatch();
        // every third stretch runs at full rate to fill rob and rs
        if (((sent / 50) % 3) == 2) begin
            return 1'b1;
        end
        return ($unsigned($random(seed)) % 10) < 7;
    endfunction

    task automatic drive_dispatch();
        if (!holding && sent < n_instr && want_dispatch()) begin
            make_instr();
            holding = 1'b1;
        end
        dispatch_valid = holding;
        dispatch_op    = cur.op;
        dispatch_dest  = cur.dest;
        dispatch_src1  = cur.src1;
        dispatch_src2  = cur.src2;
        dispatch_imm   = cur.imm;
    endtask

    task automatic check_commit();
        instr_t         head;
        ooo_pkg::word_t expected;
        if (in_flight.size() == 0) begin
            $display("commit seen with no instruction outstanding");
            abort_run();
        end else begin
            head     = in_flight.pop_front();
            expected = model_result(head);
            check_dest(commit_dest, head.dest);
            check_value(commit_value, expected);
            arch_regs[head.dest] = expected;
            committed++;
        end
    endtask

    // one clock: drive after the edge, sample at the falling edge
    task automatic run_cycle();
        @(posedge clock);
        #5;
        drive_dispatch();
        @(negedge clock);
        if (ooo_i.ooo_properties_i.fail_count != 0) begin
            $display("a concurrent assertion on the DUT failed");
            abort_run();
        end
        if (commit_valid) begin
            check_commit();
            idle_cycles = 0;
        end else if (in_flight.size() != 0) begin
            idle_cycles++;
        end
        if (dispatch_valid && dispatch_ready) begin
            in_flight.push_back(cur);
            holding = 1'b0;
            sent++;
        end
        if (!dispatch_ready) begin
            ready_low_cycles++;
        end
        if (idle_cycles > idle_limit) begin
            $display("no commit for %0d cycles with instructions outstanding", idle_limit);
            abort_run();
        end
    endtask

    initial begin
        int cycles;
        seed             = 32'h0996_484e;
        reset            = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_op      = ooo_pkg::alu_add;
        dispatch_dest    = '0;
        dispatch_src1    = '0;
        dispatch_src2    = '0;
        dispatch_imm     = '0;
        holding          = 1'b0;
        last_dest        = '0;
        burst_left       = 0;
        sent             = 0;
        committed        = 0;
        idle_cycles      = 0;
        ready_low_cycles = 0;
        cur              = '{ooo_pkg::alu_add, '0, '0, '0, '0};
        for (int i = 0; i < ooo_pkg::arch_regs; i++) begin
            arch_regs[i] = '0;
        end

        repeat (16) @(posedge clock);
        #5;
        reset = 1'b0;

        cycles = 0;
        @(negedge clock);
        while (dispatch_ready !== 1'b1) begin
            if (cycles >= ready_limit) begin
                $display("dispatch_ready did not rise after reset");
                abort_run();
            end
            cycles++;
            @(negedge clock);
        end
        if (commit_valid !== 1'b0) begin
            $display("commit_valid rose before any dispatch");
            abort_run();
        end

        cycles = 0;
        while (sent < n_instr) begin
            if (cycles >= run_limit) begin
                $display("dispatch of %0d instructions timed out", n_instr);
                abort_run();
            end
            run_cycle();
            cycles++;
        end

        // drain what is still in flight
        cycles = 0;
        while (in_flight.size() != 0) begin
            if (cycles >= 4 * idle_limit) begin
                $display("%0d instructions never committed", in_flight.size());
                abort_run();
            end
            run_cycle();
            cycles++;
        end

        if (committed == n_instr && ready_low_cycles != 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("dispatch_ready never fell or commit count is %0d", committed);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== test/ooo_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_properties (
    input logic clock,
    input logic reset,
    input logic dispatch_valid,
    input logic dispatch_ready,
    input logic commit_valid,
    input logic rob_full
);

    int unsigned fail_count = 0;

    // first edge of reset still sees an unknown rob count
    commit_quiet_in_reset: assert property (
        @(posedge clock) reset && $past(reset) |-> !commit_valid
    ) else begin
        fail_count++;
        $error("commit_valid high during reset");
    end

    ready_low_in_reset: assert property (
        @(posedge clock) reset |-> !dispatch_ready
    ) else begin
        fail_count++;
        $error("dispatch_ready high during reset");
    end

    no_dispatch_rob_full: assert property (
        @(posedge clock) disable iff (reset)
        rob_full |-> !(dispatch_valid && dispatch_ready)
    ) else begin
        fail_count++;
        $error("dispatch accepted while the rob is full");
    end

endmodule

bind ooo ooo_properties ooo_properties_i (
    .clock(clock),
    .reset(reset),
    .dispatch_valid(dispatch_valid),
    .dispatch_ready(dispatch_ready),
    .commit_valid(commit_valid),
    .rob_full(rob_full)
);

`default_nettype wire

// ==== src/ooo.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo #(
    parameter int phys_regs = 32,
    parameter int rob_sz = 8,
    parameter int rs_sz = 4
)(
    input  logic                clock,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  ooo_pkg::alu_op_t    dispatch_op,
    input  ooo_pkg::arn_t       dispatch_dest,
    input  ooo_pkg::arn_t       dispatch_src1,
    input  ooo_pkg::arn_t       dispatch_src2,
    input  ooo_pkg::word_t      dispatch_imm,
    output logic                dispatch_ready,
    output logic                commit_valid,
    output ooo_pkg::arn_t       commit_dest,
    output ooo_pkg::word_t      commit_value
);

    localparam int prn_w  = $clog2(phys_regs);
    localparam int robn_w = $clog2(rob_sz);

    logic alloc_en;
    logic rs_full;
    logic rob_full;

    logic [prn_w-1:0] src1_prn;
    logic [prn_w-1:0] src2_prn;
    logic [prn_w-1:0] dest_prn;
    logic [prn_w-1:0] dest_old_prn;
    logic [robn_w-1:0] tail_robn;

    ooo_pkg::word_t rd1_value;
    ooo_pkg::word_t rd2_value;
    logic rd1_ready;
    logic rd2_ready;

    ooo_pkg::operand_t op1;
    ooo_pkg::operand_t op2;
    logic op1_ready;
    logic op2_ready;

    logic                issue_valid;
    ooo_pkg::alu_op_t    issue_op;
    ooo_pkg::word_t      issue_a;
    ooo_pkg::word_t      issue_b;
    logic [prn_w-1:0]    issue_dest_prn;
    logic [robn_w-1:0]   issue_robn;

    logic                cdb_valid;
    logic [prn_w-1:0]    cdb_prn;
    logic [robn_w-1:0]   cdb_robn;
    ooo_pkg::word_t      cdb_value;

    logic [prn_w-1:0]    commit_prn;

    assign dispatch_ready = !reset && !rs_full && !rob_full;
    assign alloc_en       = dispatch_valid && dispatch_ready;

    // value if the source is ready, else the producer tag
    always_comb begin
        op1_ready = rd1_ready || (dispatch_op == ooo_pkg::alu_li);
        if (op1_ready) begin
            op1.value = rd1_value;
        end else begin
            op1.tag.pad = '0;
            op1.tag.prn = ooo_pkg::prn_max_w'(src1_prn);
        end
        op2_ready = rd2_ready || (dispatch_op == ooo_pkg::alu_li);
        if (dispatch_op == ooo_pkg::alu_li) begin
            op2.value = dispatch_imm;
        end else if (rd2_ready) begin
            op2.value = rd2_value;
        end else begin
            op2.tag.pad = '0;
            op2.tag.prn = ooo_pkg::prn_max_w'(src2_prn);
        end
    end

    rename_map #(.phys_regs(phys_regs)) rename_map_i (
        .clock(clock),
        .reset(reset),
        .rename_en(alloc_en),
        .src1(dispatch_src1),
        .src2(dispatch_src2),
        .dest(dispatch_dest),
        .commit_en(commit_valid),
        .commit_dest(commit_dest),
        .commit_prn(commit_prn),
        .src1_prn(src1_prn),
        .src2_prn(src2_prn),
        .dest_prn(dest_prn),
        .dest_old_prn(dest_old_prn)
    );

    prf #(.phys_regs(phys_regs)) prf_i (
        .clock(clock),
        .reset(reset),
        .rd1_prn(src1_prn),
        .rd2_prn(src2_prn),
        .cdb_valid(cdb_valid),
        .cdb_prn(cdb_prn),
        .cdb_value(cdb_value),
        .alloc_en(alloc_en),
        .alloc_prn(dest_prn),
        .commit_prn(commit_prn),
        .rd1_value(rd1_value),
        .rd2_value(rd2_value),
        .rd1_ready(rd1_ready),
        .rd2_ready(rd2_ready),
        .commit_value(commit_value)
    );

    rs #(.phys_regs(phys_regs), .rob_sz(rob_sz), .rs_sz(rs_sz)) rs_i (
        .clock(clock),
        .reset(reset),
        .alloc_en(alloc_en),
        .alloc_op(dispatch_op),
        .alloc_op1(op1),
        .alloc_op2(op2),
        .alloc_op1_ready(op1_ready),
        .alloc_op2_ready(op2_ready),
        .alloc_dest_prn(dest_prn),
        .alloc_robn(tail_robn),
        .cdb_valid(cdb_valid),
        .cdb_prn(cdb_prn),
        .cdb_value(cdb_value),
        .full(rs_full),
        .issue_valid(issue_valid),
        .issue_op(issue_op),
        .issue_a(issue_a),
        .issue_b(issue_b),
        .issue_dest_prn(issue_dest_prn),
        .issue_robn(issue_robn)
    );

    alu_cdb #(.phys_regs(phys_regs), .rob_sz(rob_sz)) alu_cdb_i (
        .clock(clock),
        .reset(reset),
        .issue_valid(issue_valid),
        .issue_op(issue_op),
        .issue_a(issue_a),
        .issue_b(issue_b),
        .issue_dest_prn(issue_dest_prn),
        .issue_robn(issue_robn),
        .cdb_valid(cdb_valid),
        .cdb_prn(cdb_prn),
        .cdb_robn(cdb_robn),
        .cdb_value(cdb_value)
    );

    // freed tag comes from the retirement map inside rename_map
    rob #(.phys_regs(phys_regs), .rob_sz(rob_sz)) rob_i (
        .clock(clock),
        .reset(reset),
        .alloc_en(alloc_en),
        .alloc_dest(dispatch_dest),
        .alloc_dest_prn(dest_prn),
        .alloc_old_prn(dest_old_prn),
        .cdb_valid(cdb_valid),
        .cdb_robn(cdb_robn),
        .full(rob_full),
        .tail_robn(tail_robn),
        .commit_valid(commit_valid),
        .commit_dest(commit_dest),
        .commit_prn(commit_prn),
        .commit_old_prn()
    );

endmodule

`default_nettype wire

// ==== src/rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob #(
    parameter int phys_regs = 32,
    parameter int rob_sz = 8,
    localparam int prn_w = $clog2(phys_regs),
    localparam int robn_w = $clog2(rob_sz)
)(
    input  logic                clock,
    input  logic                reset,
    input  logic                alloc_en,
    input  ooo_pkg::arn_t       alloc_dest,
    input  logic [prn_w-1:0]    alloc_dest_prn,
    input  logic [prn_w-1:0]    alloc_old_prn,
    input  logic                cdb_valid,
    input  logic [robn_w-1:0]   cdb_robn,
    output logic                full,
    output logic [robn_w-1:0]   tail_robn,
    output logic                commit_valid,
    output ooo_pkg::arn_t       commit_dest,
    output logic [prn_w-1:0]    commit_prn,
    output logic [prn_w-1:0]    commit_old_prn
);

    localparam int cnt_w = $clog2(rob_sz + 1);

    ooo_pkg::arn_t    dest     [rob_sz];
    logic [prn_w-1:0] dest_prn [rob_sz];
    logic [prn_w-1:0] old_prn  [rob_sz];
    logic [rob_sz-1:0] done;
    logic [robn_w-1:0] head;
    logic [robn_w-1:0] tail;
    logic [cnt_w-1:0]  count;

    assign full           = (count == cnt_w'(rob_sz));
    assign tail_robn      = tail;
    assign commit_valid   = (count != '0) && done[head];
    assign commit_dest    = dest[head];
    assign commit_prn     = dest_prn[head];
    assign commit_old_prn = old_prn[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (cdb_valid) begin
                done[cdb_robn] <= 1'b1;
            end
            if (alloc_en) begin
                dest[tail]     <= alloc_dest;
                dest_prn[tail] <= alloc_dest_prn;
                old_prn[tail]  <= alloc_old_prn;
                done[tail]     <= 1'b0;
                tail <= (tail == robn_w'(rob_sz - 1)) ? '0 : tail + 1'b1;
            end
            if (commit_valid) begin
                head <= (head == robn_w'(rob_sz - 1)) ? '0 : head + 1'b1;
            end
            count <= count + cnt_w'(alloc_en) - cnt_w'(commit_valid);
        end
    end

endmodule

`default_nettype wire

// ==== src/alu_cdb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_cdb #(
    parameter int phys_regs = 32,
    parameter int rob_sz = 8,
    localparam int prn_w = $clog2(phys_regs),
    localparam int robn_w = $clog2(rob_sz)
)(
    input  logic                clock,
    input  logic                reset,
    input  logic                issue_valid,
    input  ooo_pkg::alu_op_t    issue_op,
    input  ooo_pkg::word_t      issue_a,
    input  ooo_pkg::word_t      issue_b,
    input  logic [prn_w-1:0]    issue_dest_prn,
    input  logic [robn_w-1:0]   issue_robn,
    output logic                cdb_valid,
    output logic [prn_w-1:0]    cdb_prn,
    output logic [robn_w-1:0]   cdb_robn,
    output ooo_pkg::word_t      cdb_value
);

    ooo_pkg::word_t result;

    always_comb begin
        case (issue_op)
            ooo_pkg::alu_add: result = issue_a + issue_b;
            ooo_pkg::alu_sub: result = issue_a - issue_b;
            ooo_pkg::alu_and: result = issue_a & issue_b;
            ooo_pkg::alu_xor: result = issue_a ^ issue_b;
            // immediate rides in operand b
            default:          result = issue_b;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
        cdb_prn   <= issue_dest_prn;
        cdb_robn  <= issue_robn;
        cdb_value <= result;
    end

endmodule

`default_nettype wire

// ==== src/rs.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs #(
    parameter int phys_regs = 32,
    parameter int rob_sz = 8,
    parameter int rs_sz = 4,
    localparam int prn_w = $clog2(phys_regs),
    localparam int robn_w = $clog2(rob_sz)
)(
    input  logic                clock,
    input  logic                reset,
    input  logic                alloc_en,
    input  ooo_pkg::alu_op_t    alloc_op,
    input  ooo_pkg::operand_t   alloc_op1,
    input  ooo_pkg::operand_t   alloc_op2,
    input  logic                alloc_op1_ready,
    input  logic                alloc_op2_ready,
    input  logic [prn_w-1:0]    alloc_dest_prn,
    input  logic [robn_w-1:0]   alloc_robn,
    input  logic                cdb_valid,
    input  logic [prn_w-1:0]    cdb_prn,
    input  ooo_pkg::word_t      cdb_value,
    output logic                full,
    output logic                issue_valid,
    output ooo_pkg::alu_op_t    issue_op,
    output ooo_pkg::word_t      issue_a,
    output ooo_pkg::word_t      issue_b,
    output logic [prn_w-1:0]    issue_dest_prn,
    output logic [robn_w-1:0]   issue_robn
);

    localparam int idx_w = (rs_sz > 1) ? $clog2(rs_sz) : 1;
    // age counts the younger entries still waiting
    localparam int age_w = $clog2(rs_sz) + 1;

    logic [rs_sz-1:0]  valid;
    logic [rs_sz-1:0]  op1_ready;
    logic [rs_sz-1:0]  op2_ready;
    ooo_pkg::alu_op_t  op       [rs_sz];
    ooo_pkg::operand_t op1      [rs_sz];
    ooo_pkg::operand_t op2      [rs_sz];
    logic [prn_w-1:0]  dest_prn [rs_sz];
    logic [robn_w-1:0] robn     [rs_sz];
    logic [age_w-1:0]  age      [rs_sz];

    logic [idx_w-1:0] sel_idx;
    logic [age_w-1:0] sel_age;
    logic [idx_w-1:0] free_idx;
    logic [ooo_pkg::prn_max_w-1:0] cdb_tag;

    assign cdb_tag = ooo_pkg::prn_max_w'(cdb_prn);
    assign full    = &valid;

    always_comb begin
        issue_valid = 1'b0;
        sel_idx     = '0;
        sel_age     = '0;
        for (int i = 0; i < rs_sz; i++) begin
            if (valid[i] && op1_ready[i] && op2_ready[i] &&
                    (!issue_valid || age[i] > sel_age)) begin
                issue_valid = 1'b1;
                sel_idx     = idx_w'(i);
                sel_age     = age[i];
            end
        end
        free_idx = '0;
        for (int i = rs_sz - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = idx_w'(i);
            end
        end
    end

    assign issue_op       = op[sel_idx];
    assign issue_a        = op1[sel_idx].value;
    assign issue_b        = op2[sel_idx].value;
    assign issue_dest_prn = dest_prn[sel_idx];
    assign issue_robn     = robn[sel_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            for (int i = 0; i < rs_sz; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < rs_sz; i++) begin
                age[i] <= age[i] + age_w'(alloc_en)
                        - age_w'(issue_valid && age[i] > sel_age);
                if (issue_valid && sel_idx == idx_w'(i)) begin
                    valid[i] <= 1'b0;
                end
                // wakeup, the tag is overwritten by the value
                if (cdb_valid && !op1_ready[i] && op1[i].tag.prn == cdb_tag) begin
                    op1[i].value <= cdb_value;
                    op1_ready[i] <= 1'b1;
                end
                if (cdb_valid && !op2_ready[i] && op2[i].tag.prn == cdb_tag) begin
                    op2[i].value <= cdb_value;
                    op2_ready[i] <= 1'b1;
                end
                if (alloc_en && free_idx == idx_w'(i)) begin
                    valid[i]     <= 1'b1;
                    age[i]       <= '0;
                    op[i]        <= alloc_op;
                    op1[i]       <= alloc_op1;
                    op2[i]       <= alloc_op2;
                    op1_ready[i] <= alloc_op1_ready;
                    op2_ready[i] <= alloc_op2_ready;
                    dest_prn[i]  <= alloc_dest_prn;
                    robn[i]      <= alloc_robn;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/prf.sv ====
`timescale 1ns/1ps
`default_nettype none

module prf #(
    parameter int phys_regs = 32,
    localparam int prn_w = $clog2(phys_regs)
)(
    input  logic                clock,
    input  logic                reset,
    input  logic [prn_w-1:0]    rd1_prn,
    input  logic [prn_w-1:0]    rd2_prn,
    input  logic                cdb_valid,
    input  logic [prn_w-1:0]    cdb_prn,
    input  ooo_pkg::word_t      cdb_value,
    input  logic                alloc_en,
    input  logic [prn_w-1:0]    alloc_prn,
    input  logic [prn_w-1:0]    commit_prn,
    output ooo_pkg::word_t      rd1_value,
    output ooo_pkg::word_t      rd2_value,
    output logic                rd1_ready,
    output logic                rd2_ready,
    output ooo_pkg::word_t      commit_value
);

    ooo_pkg::word_t regs [phys_regs];
    logic [phys_regs-1:0] ready;
    logic rd1_hit;
    logic rd2_hit;

    // bypass so a value broadcast during rename is not missed
    assign rd1_hit   = cdb_valid && (cdb_prn == rd1_prn);
    assign rd2_hit   = cdb_valid && (cdb_prn == rd2_prn);
    assign rd1_value = rd1_hit ? cdb_value : regs[rd1_prn];
    assign rd2_value = rd2_hit ? cdb_value : regs[rd2_prn];
    assign rd1_ready = rd1_hit || ready[rd1_prn];
    assign rd2_ready = rd2_hit || ready[rd2_prn];

    assign commit_value = regs[commit_prn];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < phys_regs; i++) begin
                regs[i] <= '0;
            end
            ready <= '1;
        end else begin
            if (cdb_valid) begin
                regs[cdb_prn]  <= cdb_value;
                ready[cdb_prn] <= 1'b1;
            end
            // a freshly allocated tag is never the one on the bus
            if (alloc_en) begin
                ready[alloc_prn] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/rename_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_map #(
    parameter int phys_regs = 32,
    localparam int prn_w = $clog2(phys_regs)
)(
    input  logic                clock,
    input  logic                reset,
    input  logic                rename_en,
    input  ooo_pkg::arn_t       src1,
    input  ooo_pkg::arn_t       src2,
    input  ooo_pkg::arn_t       dest,
    input  logic                commit_en,
    input  ooo_pkg::arn_t       commit_dest,
    input  logic [prn_w-1:0]    commit_prn,
    output logic [prn_w-1:0]    src1_prn,
    output logic [prn_w-1:0]    src2_prn,
    output logic [prn_w-1:0]    dest_prn,
    output logic [prn_w-1:0]    dest_old_prn
);

    localparam int fl_sz = phys_regs - ooo_pkg::arch_regs;
    localparam int fl_w  = $clog2(fl_sz);

    logic [prn_w-1:0] spec_map   [ooo_pkg::arch_regs];
    logic [prn_w-1:0] retire_map [ooo_pkg::arch_regs];
    logic [prn_w-1:0] free_list  [fl_sz];
    logic [fl_w-1:0]  fl_head;
    logic [fl_w-1:0]  fl_tail;
    logic [fl_w-1:0]  fl_head_next;
    logic [fl_w-1:0]  fl_tail_next;

    assign src1_prn     = spec_map[src1];
    assign src2_prn     = spec_map[src2];
    assign dest_prn     = free_list[fl_head];
    assign dest_old_prn = spec_map[dest];

    assign fl_head_next = (fl_head == fl_w'(fl_sz - 1)) ? '0 : fl_head + 1'b1;
    assign fl_tail_next = (fl_tail == fl_w'(fl_sz - 1)) ? '0 : fl_tail + 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::arch_regs; i++) begin
                spec_map[i]   <= prn_w'(i);
                retire_map[i] <= prn_w'(i);
            end
            for (int i = 0; i < fl_sz; i++) begin
                free_list[i] <= prn_w'(i + ooo_pkg::arch_regs);
            end
            fl_head <= '0;
            // list starts full, tail wraps onto head
            fl_tail <= '0;
        end else begin
            if (rename_en) begin
                spec_map[dest] <= free_list[fl_head];
                fl_head        <= fl_head_next;
            end
            if (commit_en) begin
                // in-order commit, so the retired mapping is the one being replaced
                retire_map[commit_dest] <= commit_prn;
                free_list[fl_tail]      <= retire_map[commit_dest];
                fl_tail                 <= fl_tail_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    localparam int xlen      = 32;
    localparam int arch_regs = 8;
    localparam int arn_w     = 3;

    // widest tag an operand slot can carry, so phys_regs <= 256
    localparam int prn_max_w = 8;

    typedef logic [xlen-1:0]  word_t;
    typedef logic [arn_w-1:0] arn_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_xor,
        alu_li
    } alu_op_t;

    typedef struct packed {
        logic [xlen-prn_max_w-1:0] pad;
        logic [prn_max_w-1:0]      prn;
    } tag_t;

    // rs operand slot, a value once ready, a producer tag before that
    typedef union packed {
        word_t value;
        tag_t  tag;
    } operand_t;

endpackage

`default_nettype wire
